// File: tb/stk_tests.dat
# op eng data status exp_data, all hex
# op 0 push 1 pop 2 peek; status 0 ok 1 empty 2 full
# LIFO order and PEEK on engine 0
0 0 00000011 0 00000000
0 0 00000022 0 00000000
0 0 00000033 0 00000000
1 0 00000000 0 00000033
2 0 00000000 0 00000022
1 0 00000000 0 00000022
1 0 00000000 0 00000011
# Empty stack, then reuse
1 0 00000000 1 00000000
2 0 00000000 1 00000000
0 0 00000044 0 00000000
1 0 00000000 0 00000044
# All four engines interleaved
0 1 000000a1 0 00000000
0 2 000000b1 0 00000000
0 3 000000c1 0 00000000
0 1 000000a2 0 00000000
1 1 00000000 0 000000a2
1 1 00000000 0 000000a1
2 2 00000000 0 000000b1
1 2 00000000 0 000000b1
1 3 00000000 0 000000c1
1 1 00000000 1 00000000
1 2 00000000 1 00000000
# Push then pop, pop then push, same engine
0 3 000000d1 0 00000000
1 3 00000000 0 000000d1
0 0 00000055 0 00000000
0 0 00000066 0 00000000
1 0 00000000 0 00000066
0 0 00000077 0 00000000
1 0 00000000 0 00000077
1 0 00000000 0 00000055
# Fill all sixteen lines
0 0 00000100 0 00000000
0 1 00000101 0 00000000
0 2 00000102 0 00000000
0 3 00000103 0 00000000
0 0 00000104 0 00000000
0 1 00000105 0 00000000
0 2 00000106 0 00000000
0 3 00000107 0 00000000
0 0 00000108 0 00000000
0 1 00000109 0 00000000
0 2 0000010a 0 00000000
0 3 0000010b 0 00000000
0 0 0000010c 0 00000000
0 1 0000010d 0 00000000
0 2 0000010e 0 00000000
0 3 0000010f 0 00000000
# No line left
0 1 00000200 2 00000000
# Free one line, peeks give the release time to land
1 2 00000000 0 0000010e
2 0 00000000 0 0000010c
2 3 00000000 0 0000010f
0 1 00000201 0 00000000
1 1 00000000 0 00000201
1 1 00000000 0 0000010d

// File: list.f
logic/stk_pkg.sv
logic/stk_pipe_mem_sram.sv
logic/stk_pipe_alloc.sv
logic/stk_pipe_lk.sv
logic/stk_pipe_mem.sv
logic/stk_pipe.sv
tb/stk_tb_clk.sv
tb/stk_tb_check.sv
tb/stk_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Mdir obj_dir --top-module stk_tb -f list.f -o stk_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/stk_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" sim.log; then
  exit 0
else
  exit 1
fi

// File: tb/stk_tb.sv
module stk_tb;

  localparam int DATA_W = 32;
  localparam int PERIOD = 4;
  localparam int RESET_CYC = 8;
  // Watchdog budget per command
  localparam int CYC_PER_TEST = 20;

  // One line of the tests file
  typedef struct packed {
    stk_pkg::opcode_t op;
    stk_pkg::engid_t eng;
    logic [DATA_W-1:0] dat;
    stk_pkg::status_t status;
    logic [DATA_W-1:0] exp_dat;
  } test_t;

  logic clk;
  logic reset;
  // Command port
  logic cmd_vld;
  stk_pkg::cmd_t cmd;
  logic [DATA_W-1:0] cmd_dat;
  logic cmd_rdy;
  // Response port
  logic rsp_vld;
  stk_pkg::wrbk_t rsp;
  logic [DATA_W-1:0] rsp_dat;
  // Expected values, held alongside the command
  stk_pkg::status_t exp_status;
  logic [DATA_W-1:0] exp_dat;
  logic done;
  int rsp_cnt;
  int err_cnt;
  test_t tests [$];
  logic [31:0] lcg_state;
  logic load_fail;
  logic timed_out;
  time wd_limit;

  stk_tb_clk #(.PERIOD(PERIOD)) clk0 (.o_clk(clk));

  stk_pipe #(.DATA_W(DATA_W)) dut0 (
    .clk(clk), .i_reset(reset)
  , .i_cmd_vld(cmd_vld), .i_cmd(cmd), .i_cmd_dat(cmd_dat), .o_cmd_rdy(cmd_rdy)
  , .o_rsp_vld(rsp_vld), .o_rsp(rsp), .o_rsp_dat(rsp_dat)
  );

  stk_tb_check #(.DATA_W(DATA_W)) check0 (
    .clk(clk), .i_reset(reset)
  , .i_cmd_vld(cmd_vld), .i_cmd_rdy(cmd_rdy), .i_cmd(cmd)
  , .i_exp_status(exp_status), .i_exp_dat(exp_dat)
  , .i_rsp_vld(rsp_vld), .i_rsp(rsp), .i_rsp_dat(rsp_dat)
  , .i_done(done), .o_rsp_cnt(rsp_cnt), .o_err_cnt(err_cnt)
  );

  // LCG for idle gaps between commands
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Columns: op, engine, data, expected status, expected data (hex)
  task automatic load_tests();
    int fd;
    int n;
    string line;
    logic [31:0] f_op;
    logic [31:0] f_eng;
    logic [31:0] f_dat;
    logic [31:0] f_st;
    logic [31:0] f_edat;
    test_t t;
    fd = $fopen("tb/stk_tests.dat", "r");
    if (fd == 0) begin
      $display("Cannot open tb/stk_tests.dat");
      load_fail = 1'b1;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comment lines
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h", f_op, f_eng, f_dat, f_st, f_edat);
          if (n == 5) begin
            t.op = stk_pkg::opcode_t'(f_op[1:0]);
            t.eng = stk_pkg::engid_t'(f_eng[stk_pkg::ENGID_W-1:0]);
            t.dat = f_dat;
            t.status = stk_pkg::status_t'(f_st[1:0]);
            t.exp_dat = f_edat;
            tests.push_back(t);
          end else if (n > 0) begin
            $display("Malformed line in the tests file: %s", line);
            load_fail = 1'b1;
          end
        end
      end
      $fclose(fd);
    end
    if (tests.size() == 0) begin
      $display("No commands found in the tests file");
      load_fail = 1'b1;
    end
  endtask

  // Present one command, hold it until it transfers
  task automatic send_cmd(input test_t t);
    int gap;
    logic taken;
    gap = int'(next_rand() >> 16) % 3;
    if (gap > 0) begin
      cmd_vld = 1'b0;
      repeat (gap) @(posedge clk);
      #1;
    end
    cmd_vld = 1'b1;
    cmd.opcode = t.op;
    cmd.engid = t.eng;
    cmd_dat = t.dat;
    exp_status = t.status;
    exp_dat = t.exp_dat;
    taken = 1'b0;
    while (!taken) begin
      // Ready seen mid-cycle holds for the coming edge
      @(negedge clk);
      taken = cmd_rdy;
      @(posedge clk);
    end
    #1;
    cmd_vld = 1'b0;
  endtask

  task automatic run_tests();
    reset = 1'b1;
    repeat (RESET_CYC) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (tests[i]) begin
      send_cmd(tests[i]);
    end
    wait (rsp_cnt == tests.size());
    // Room for a stray extra response
    repeat (4) @(negedge clk);
  endtask

  task automatic end_run();
    if (timed_out) begin
      $display("Timeout: not every command got its response in time");
    end
    done = 1'b1;
    #1;
    if (!timed_out && !load_fail && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  endtask

  initial begin
    cmd_vld = 1'b0;
    cmd = '0;
    cmd_dat = '0;
    exp_status = stk_pkg::STATUS_OK;
    exp_dat = '0;
    reset = 1'b1;
    done = 1'b0;
    load_fail = 1'b0;
    timed_out = 1'b0;
    lcg_state = 32'h5ed63215;
    load_tests();
    wd_limit = time'((tests.size() * CYC_PER_TEST + RESET_CYC) * PERIOD);
    fork
      begin
        run_tests();
      end
      begin
        // Watchdog
        #(wd_limit);
        timed_out = 1'b1;
      end
    join_any
    end_run();
  end

endmodule : stk_tb

// File: tb/stk_tb_check.sv
module stk_tb_check #(
  parameter int DATA_W = 32
) (
  input wire logic              clk
, input wire logic              i_reset
// Command handshake and its expected result
, input wire logic              i_cmd_vld
, input wire logic              i_cmd_rdy
, input wire stk_pkg::cmd_t     i_cmd
, input wire stk_pkg::status_t  i_exp_status
, input wire logic [DATA_W-1:0] i_exp_dat
// DUT response
, input wire logic              i_rsp_vld
, input wire stk_pkg::wrbk_t    i_rsp
, input wire logic [DATA_W-1:0] i_rsp_dat
, input wire logic              i_done
, output int                    o_rsp_cnt
, output int                    o_err_cnt
);

  // One accepted command waiting for its response
  typedef struct packed {
    stk_pkg::cmd_t cmd;
    stk_pkg::status_t status;
    logic [DATA_W-1:0] dat;
    logic head_vld;
    logic [stk_pkg::PTR_W-1:0] head_ptr;
    logic rel_vld;
    logic [stk_pkg::PTR_W-1:0] rel_ptr;
    logic [31:0] cyc;
  } exp_t;

  exp_t exp_q [$];
  exp_t exp_cur;
  exp_t exp_new;
  logic [31:0] cyc;
  // Reference model of the free lines and of each stack
  logic [stk_pkg::PTRS_N-1:0] free_m;
  logic [stk_pkg::PTR_W-1:0] stk_m [stk_pkg::ENG_N][stk_pkg::PTRS_N];
  int depth_m [stk_pkg::ENG_N];
  // Line that becomes free at the coming edge
  logic rel_now;
  logic [stk_pkg::PTR_W-1:0] rel_line;
  // Command taken at the last edge
  logic last_acc;
  stk_pkg::cmd_t last_cmd;
  logic stall_exp;

  initial begin
    o_rsp_cnt = 0;
    o_err_cnt = 0;
    cyc = '0;
    last_acc = 1'b0;
  end

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      o_err_cnt++;
      $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Lowest-numbered free line, or -1 when none is left
  function automatic int lowest_free(input logic [stk_pkg::PTRS_N-1:0] map);
    int idx;
    idx = 0;
    while (idx < stk_pkg::PTRS_N && !map[idx]) begin
      idx++;
    end
    if (idx == stk_pkg::PTRS_N) begin
      idx = -1;
    end
    return idx;
  endfunction

  // Apply one accepted command to the model and fill in the expected head
  task automatic predict(inout exp_t e);
    int eng;
    int line;
    stk_pkg::status_t st_m;
    eng = int'(e.cmd.engid);
    line = lowest_free(free_m);
    if (e.cmd.opcode == stk_pkg::OPCODE_PUSH) begin
      st_m = (line >= 0) ? stk_pkg::STATUS_OK : stk_pkg::STATUS_FULL;
    end else begin
      st_m = (depth_m[eng] > 0) ? stk_pkg::STATUS_OK : stk_pkg::STATUS_EMPTY;
    end
    if (st_m != e.status) begin
      o_err_cnt++;
      $display("At %0t the tests file expects status %0d where the stack model gives %0d",
               $time, e.status, st_m);
    end
    e.rel_vld = 1'b0;
    e.rel_ptr = '0;
    if (st_m == stk_pkg::STATUS_OK) begin
      if (e.cmd.opcode == stk_pkg::OPCODE_PUSH) begin
        free_m[line] = 1'b0;
        stk_m[eng][depth_m[eng]] = stk_pkg::PTR_W'(line);
        depth_m[eng]++;
      end else if (e.cmd.opcode == stk_pkg::OPCODE_POP) begin
        depth_m[eng]--;
        e.rel_vld = 1'b1;
        e.rel_ptr = stk_m[eng][depth_m[eng]];
      end
    end
    // Head after the command is the top of the model stack
    e.head_vld = (depth_m[eng] > 0);
    e.head_ptr = '0;
    if (depth_m[eng] > 0) begin
      e.head_ptr = stk_m[eng][depth_m[eng] - 1];
    end
  endtask

  // Sampled mid-cycle away from the rising edge
  always @(negedge clk) begin
    rel_now = 1'b0;
    if (i_reset) begin
      exp_q.delete();
      free_m = '1;
      foreach (depth_m[e]) begin
        depth_m[e] = 0;
      end
      last_acc = 1'b0;
    end else begin
      if (i_rsp_vld) begin
        if (exp_q.size() == 0) begin
          o_err_cnt++;
          $display("Response at %0t with no command outstanding", $time);
        end else begin
          // Responses come back in command order
          exp_cur = exp_q.pop_front();
          o_rsp_cnt++;
          compare_value("o_rsp.engid", 32'(i_rsp.engid), 32'(exp_cur.cmd.engid));
          compare_value("o_rsp.opcode", 32'(i_rsp.opcode), 32'(exp_cur.cmd.opcode));
          compare_value("o_rsp.status", 32'(i_rsp.status), 32'(exp_cur.status));
          // Data only means something for a good POP or PEEK
          if (exp_cur.status == stk_pkg::STATUS_OK &&
              exp_cur.cmd.opcode != stk_pkg::OPCODE_PUSH) begin
            compare_value("o_rsp_dat", 32'(i_rsp_dat), 32'(exp_cur.dat));
          end
          compare_value("o_rsp.head_vld", 32'(i_rsp.head_vld), 32'(exp_cur.head_vld));
          if (exp_cur.head_vld) begin
            compare_value("o_rsp.head_ptr", 32'(i_rsp.head_ptr.raw), 32'(exp_cur.head_ptr));
          end
          compare_value("o_rsp.rel_vld", 32'(i_rsp.rel_vld), 32'(exp_cur.rel_vld));
          if (exp_cur.rel_vld) begin
            compare_value("o_rsp.rel_ptr", 32'(i_rsp.rel_ptr.raw), 32'(exp_cur.rel_ptr));
          end
          compare_value("response latency", cyc - exp_cur.cyc, 32'd2);
          // Popped line is free again from the coming edge
          rel_now = exp_cur.rel_vld;
          rel_line = exp_cur.rel_ptr;
        end
      end
      // Ready drops only behind a POP or PEEK on the same engine
      if (i_cmd_vld) begin
        stall_exp = last_acc && (last_cmd.engid == i_cmd.engid) &&
                    (last_cmd.opcode != stk_pkg::OPCODE_PUSH);
        compare_value("o_cmd_rdy", 32'(i_cmd_rdy), 32'(!stall_exp));
      end
      last_acc = i_cmd_vld && i_cmd_rdy;
      last_cmd = i_cmd;
      // Transfer happens on the coming edge
      if (i_cmd_vld && i_cmd_rdy) begin
        exp_new.cmd = i_cmd;
        exp_new.status = i_exp_status;
        exp_new.dat = i_exp_dat;
        exp_new.cyc = cyc;
        predict(exp_new);
        exp_q.push_back(exp_new);
      end
      // A PUSH taken at the same edge does not see the released line yet
      if (rel_now) begin
        free_m[rel_line] = 1'b1;
      end
    end
    cyc++;
  end

  always @(posedge i_done) begin
    $display("Responses checked: %0d, outstanding: %0d, errors: %0d",
             o_rsp_cnt, exp_q.size(), o_err_cnt);
  end

endmodule : stk_tb_check

// File: tb/stk_tb_clk.sv
module stk_tb_clk #(
  parameter int PERIOD = 4
) (
  output logic o_clk
);

  // Free-running clock, starts low
  initial begin
    o_clk = 1'b0;
    forever begin
      #(PERIOD / 2);
      o_clk = ~o_clk;
    end
  end

endmodule : stk_tb_clk

// File: logic/stk_pipe.sv
module stk_pipe #(
  parameter int DATA_W = 32
) (
  input wire logic              clk
, input wire logic              i_reset
// Command port
, input wire logic              i_cmd_vld
, input wire stk_pkg::cmd_t     i_cmd
, input wire logic [DATA_W-1:0] i_cmd_dat
, output logic                  o_cmd_rdy
// Response port
, output logic                  o_rsp_vld
, output stk_pkg::wrbk_t        o_rsp
, output logic [DATA_W-1:0]     o_rsp_dat
);

  // Allocator
  logic free_vld;
  stk_pkg::ptr_u free_ptr;
  logic alloc_take;
  // LK to SRAMs
  logic [stk_pkg::BANKS_N-1:0] link_ce;
  logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] link_raddr;
  logic [stk_pkg::BANKS_N-1:0] link_we;
  logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] link_waddr;
  stk_pkg::link_t [stk_pkg::BANKS_N-1:0] link_din;
  logic [stk_pkg::BANKS_N-1:0] dat_ce;
  logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] dat_raddr;
  logic [stk_pkg::BANKS_N-1:0] dat_we;
  logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] dat_waddr;
  logic [stk_pkg::BANKS_N-1:0][DATA_W-1:0] dat_din;
  // LK to MEM
  logic uc_vld;
  stk_pkg::uc_t uc;

  stk_pipe_lk #(.DATA_W(DATA_W)) u_lk (
    .clk(clk), .i_reset(i_reset)
  , .i_cmd_vld(i_cmd_vld), .i_cmd(i_cmd), .i_cmd_dat(i_cmd_dat), .o_cmd_rdy(o_cmd_rdy)
  , .i_free_vld(free_vld), .i_free_ptr(free_ptr), .o_alloc_take(alloc_take)
  , .i_wrbk_vld(o_rsp_vld), .i_wrbk(o_rsp)
  , .o_link_ce(link_ce), .o_link_raddr(link_raddr), .o_link_we(link_we)
  , .o_link_waddr(link_waddr), .o_link_din(link_din)
  , .o_dat_ce(dat_ce), .o_dat_raddr(dat_raddr), .o_dat_we(dat_we)
  , .o_dat_waddr(dat_waddr), .o_dat_din(dat_din)
  , .o_uc_vld(uc_vld), .o_uc(uc)
  );

  stk_pipe_alloc u_alloc (
    .clk(clk), .i_reset(i_reset), .i_take(alloc_take)
  , .i_wrbk_vld(o_rsp_vld), .i_wrbk(o_rsp)
  , .o_free_vld(free_vld), .o_free_ptr(free_ptr)
  );

  // WRBK microcode doubles as the response
  stk_pipe_mem #(.DATA_W(DATA_W)) u_mem (
    .i_link_ce(link_ce), .i_link_raddr(link_raddr), .i_link_we(link_we)
  , .i_link_waddr(link_waddr), .i_link_din(link_din)
  , .i_dat_ce(dat_ce), .i_dat_raddr(dat_raddr), .i_dat_we(dat_we)
  , .i_dat_waddr(dat_waddr), .i_dat_din(dat_din)
  , .i_uc_vld(uc_vld), .i_uc(uc), .clk(clk), .i_reset(i_reset)
  , .o_wrbk_vld(o_rsp_vld), .o_wrbk(o_rsp), .o_wrbk_dat(o_rsp_dat)
  );

endmodule : stk_pipe

// File: logic/stk_pipe_mem.sv
module stk_pipe_mem #(
  parameter int DATA_W = 32
) (
// Link SRAM
  input wire logic [stk_pkg::BANKS_N-1:0]                      i_link_ce
, input wire logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] i_link_raddr
, input wire logic [stk_pkg::BANKS_N-1:0]                      i_link_we
, input wire logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] i_link_waddr
, input wire stk_pkg::link_t [stk_pkg::BANKS_N-1:0]            i_link_din
// Data SRAM
, input wire logic [stk_pkg::BANKS_N-1:0]                      i_dat_ce
, input wire logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] i_dat_raddr
, input wire logic [stk_pkg::BANKS_N-1:0]                      i_dat_we
, input wire logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] i_dat_waddr
, input wire logic [stk_pkg::BANKS_N-1:0][DATA_W-1:0]          i_dat_din
// LK microcode
, input wire logic            i_uc_vld
, input wire stk_pkg::uc_t    i_uc
, input wire logic            clk
, input wire logic            i_reset
// WRBK microcode
, output logic                o_wrbk_vld
, output stk_pkg::wrbk_t      o_wrbk
, output logic [DATA_W-1:0]   o_wrbk_dat
);

  stk_pkg::link_t [stk_pkg::BANKS_N-1:0] link_dout;
  logic [stk_pkg::BANKS_N-1:0][DATA_W-1:0] dat_dout;
  stk_pkg::link_t link_sel;
  logic [DATA_W-1:0] dat_sel;
  // MDAT microcode
  logic mdat_vld_q;
  stk_pkg::uc_t mdat_uc_q;
  logic is_pop;
  logic is_peek;
  logic ok;

  for (genvar bnk = 0; bnk < stk_pkg::BANKS_N; bnk++) begin : sram_gen
    // Previous-line pointers
    stk_pipe_mem_sram #(.W($bits(stk_pkg::link_t)), .DEPTH(stk_pkg::LINES_N)) u_link (
      .clk(clk), .i_ce(i_link_ce[bnk]), .i_raddr(i_link_raddr[bnk])
    , .i_we(i_link_we[bnk]), .i_waddr(i_link_waddr[bnk])
    , .i_din(i_link_din[bnk]), .o_dout(link_dout[bnk])
    );
    // Pushed words
    stk_pipe_mem_sram #(.W(DATA_W), .DEPTH(stk_pkg::LINES_N)) u_dat (
      .clk(clk), .i_ce(i_dat_ce[bnk]), .i_raddr(i_dat_raddr[bnk])
    , .i_we(i_dat_we[bnk]), .i_waddr(i_dat_waddr[bnk])
    , .i_din(i_dat_din[bnk]), .o_dout(dat_dout[bnk])
    );
  end : sram_gen

  // MEM to MDAT in step with the SRAM read data
  always_ff @(posedge clk) begin
    if (i_reset) begin
      mdat_vld_q <= 1'b0;
    end else begin
      mdat_vld_q <= i_uc_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (i_uc_vld) begin
      mdat_uc_q <= i_uc;
    end
  end

  // One-hot bank select
  always_comb begin
    link_sel = '0;
    dat_sel = '0;
    for (int b = 0; b < stk_pkg::BANKS_N; b++) begin
      if (mdat_uc_q.bank[b]) begin
        link_sel = link_dout[b];
        dat_sel = dat_dout[b];
      end
    end
  end

  // Opcode decode
  assign is_pop = (mdat_uc_q.opcode == stk_pkg::OPCODE_POP);
  assign is_peek = (mdat_uc_q.opcode == stk_pkg::OPCODE_PEEK);
  assign ok = (mdat_uc_q.status == stk_pkg::STATUS_OK);

  // MDAT to WRBK
  assign o_wrbk_vld = mdat_vld_q;
  assign o_wrbk.engid = mdat_uc_q.engid;
  assign o_wrbk.opcode = mdat_uc_q.opcode;
  assign o_wrbk.status = mdat_uc_q.status;
  // POP takes the next head from the link word
  assign o_wrbk.head_vld = mdat_uc_q.head_upt ? link_sel.vld : mdat_uc_q.head_vld;
  assign o_wrbk.head_ptr = mdat_uc_q.head_upt ? link_sel.ptr : mdat_uc_q.head_ptr;
  // Popped line goes back to the allocator
  assign o_wrbk.rel_vld = is_pop && ok;
  assign o_wrbk.rel_ptr = mdat_uc_q.head_ptr;
  assign o_wrbk_dat = ((is_pop || is_peek) && ok) ? dat_sel : '0;

endmodule : stk_pipe_mem

// File: logic/stk_pipe_lk.sv
module stk_pipe_lk #(
  parameter int DATA_W = 32
) (
  input wire logic            clk
, input wire logic            i_reset
, input wire logic            i_cmd_vld
, input wire stk_pkg::cmd_t   i_cmd
, input wire logic [DATA_W-1:0] i_cmd_dat
, output logic                o_cmd_rdy
, input wire logic            i_free_vld
, input wire stk_pkg::ptr_u   i_free_ptr
, output logic                o_alloc_take
, input wire logic            i_wrbk_vld
, input wire stk_pkg::wrbk_t  i_wrbk
// Link SRAM
, output logic [stk_pkg::BANKS_N-1:0]                     o_link_ce
, output logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] o_link_raddr
, output logic [stk_pkg::BANKS_N-1:0]                     o_link_we
, output logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] o_link_waddr
, output stk_pkg::link_t [stk_pkg::BANKS_N-1:0]           o_link_din
// Data SRAM
, output logic [stk_pkg::BANKS_N-1:0]                     o_dat_ce
, output logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] o_dat_raddr
, output logic [stk_pkg::BANKS_N-1:0]                     o_dat_we
, output logic [stk_pkg::BANKS_N-1:0][stk_pkg::LINE_W-1:0] o_dat_waddr
, output logic [stk_pkg::BANKS_N-1:0][DATA_W-1:0]         o_dat_din
// Microcode to MEM
, output logic                o_uc_vld
, output stk_pkg::uc_t        o_uc
);

  stk_pkg::engid_t eng;
  logic is_push;
  logic fwd;
  logic cur_vld;
  stk_pkg::ptr_u cur_ptr;
  logic push_ok;
  logic rd_ok;
  logic accept;
  logic [stk_pkg::BANKS_N-1:0] rd_oh;
  logic [stk_pkg::BANKS_N-1:0] wr_oh;
  stk_pkg::uc_t uc_nxt;
  // Head table, one entry per engine
  logic [stk_pkg::ENG_N-1:0] head_vld_q;
  stk_pkg::ptr_u [stk_pkg::ENG_N-1:0] head_ptr_q;
  // SRAM drive, same for link and data
  logic [stk_pkg::BANKS_N-1:0] ce_q;
  logic [stk_pkg::BANKS_N-1:0] we_q;
  logic [stk_pkg::LINE_W-1:0] raddr_q;
  logic [stk_pkg::LINE_W-1:0] waddr_q;
  stk_pkg::link_t link_din_q;
  logic [DATA_W-1:0] dat_din_q;

  assign eng = i_cmd.engid;
  assign is_push = (i_cmd.opcode == stk_pkg::OPCODE_PUSH);

  // Head of a POP/PEEK in MEM not known yet
  assign o_cmd_rdy = !(o_uc_vld && (o_uc.engid == eng) &&
                       ((o_uc.opcode == stk_pkg::OPCODE_POP) ||
                        (o_uc.opcode == stk_pkg::OPCODE_PEEK)));
  assign accept = i_cmd_vld && o_cmd_rdy;

  // Forward the POP head being written back this cycle
  assign fwd = i_wrbk_vld && i_wrbk.rel_vld && (i_wrbk.engid == eng);
  assign cur_vld = fwd ? i_wrbk.head_vld : head_vld_q[eng];
  assign cur_ptr = fwd ? i_wrbk.head_ptr : head_ptr_q[eng];

  assign push_ok = is_push && i_free_vld;
  assign rd_ok = !is_push && cur_vld;
  assign o_alloc_take = accept && push_ok;

  always_comb begin
    // Bank decode, read at head, write at new line
    for (int b = 0; b < stk_pkg::BANKS_N; b++) begin
      rd_oh[b] = (int'(cur_ptr.fld.bank) == b);
      wr_oh[b] = (int'(i_free_ptr.fld.bank) == b);
    end
    uc_nxt.engid = eng;
    uc_nxt.opcode = i_cmd.opcode;
    if (is_push) begin
      uc_nxt.status = i_free_vld ? stk_pkg::STATUS_OK : stk_pkg::STATUS_FULL;
    end else begin
      uc_nxt.status = cur_vld ? stk_pkg::STATUS_OK : stk_pkg::STATUS_EMPTY;
    end
    uc_nxt.bank = is_push ? wr_oh : rd_oh;
    // Only POP moves the head down the list
    uc_nxt.head_upt = (i_cmd.opcode == stk_pkg::OPCODE_POP) && cur_vld;
    uc_nxt.head_vld = push_ok ? 1'b1 : cur_vld;
    uc_nxt.head_ptr = push_ok ? i_free_ptr : cur_ptr;
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_uc_vld <= 1'b0;
      ce_q <= '0;
      we_q <= '0;
      head_vld_q <= '0;
    end else begin
      o_uc_vld <= accept;
      ce_q <= (accept && rd_ok) ? rd_oh : '0;
      we_q <= (accept && push_ok) ? wr_oh : '0;
      // Writeback first, a PUSH in the same cycle wins
      if (i_wrbk_vld && i_wrbk.rel_vld) begin
        head_vld_q[i_wrbk.engid] <= i_wrbk.head_vld;
      end
      if (accept && push_ok) begin
        head_vld_q[eng] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_wrbk_vld && i_wrbk.rel_vld) begin
      head_ptr_q[i_wrbk.engid] <= i_wrbk.head_ptr;
    end
    if (accept && push_ok) begin
      head_ptr_q[eng] <= i_free_ptr;
    end
    if (accept) begin
      o_uc <= uc_nxt;
      raddr_q <= cur_ptr.fld.line;
      waddr_q <= i_free_ptr.fld.line;
      // New line links back to the old head
      link_din_q.vld <= cur_vld;
      link_din_q.ptr <= cur_ptr;
      dat_din_q <= i_cmd_dat;
    end
  end

  // Address and data go to every bank, enables pick one
  assign o_link_ce = ce_q;
  assign o_link_we = we_q;
  assign o_link_raddr = {stk_pkg::BANKS_N{raddr_q}};
  assign o_link_waddr = {stk_pkg::BANKS_N{waddr_q}};
  assign o_link_din = {stk_pkg::BANKS_N{link_din_q}};
  assign o_dat_ce = ce_q;
  assign o_dat_we = we_q;
  assign o_dat_raddr = {stk_pkg::BANKS_N{raddr_q}};
  assign o_dat_waddr = {stk_pkg::BANKS_N{waddr_q}};
  assign o_dat_din = {stk_pkg::BANKS_N{dat_din_q}};

endmodule : stk_pipe_lk

// File: logic/stk_pipe_alloc.sv
module stk_pipe_alloc (
  input wire logic            clk
, input wire logic            i_reset
, input wire logic            i_take
, input wire logic            i_wrbk_vld
, input wire stk_pkg::wrbk_t  i_wrbk
, output logic                o_free_vld
, output stk_pkg::ptr_u       o_free_ptr
);

  // One bit per line, set when free
  logic [stk_pkg::PTRS_N-1:0] free_q;
  logic rel;

  // Line given back by a successful POP
  assign rel = i_wrbk_vld && i_wrbk.rel_vld && (i_wrbk.opcode == stk_pkg::OPCODE_POP);

  // Find first free, lowest index wins
  always_comb begin
    o_free_vld = 1'b0;
    o_free_ptr = '0;
    for (int i = stk_pkg::PTRS_N - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        o_free_vld = 1'b1;
        o_free_ptr.raw = stk_pkg::PTR_W'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      // Every line starts free
      free_q <= '1;
    end else begin
      if (rel) begin
        free_q[i_wrbk.rel_ptr.raw] <= 1'b1;
      end
      // Offered line is never the released one
      if (i_take) begin
        free_q[o_free_ptr.raw] <= 1'b0;
      end
    end
  end

endmodule : stk_pipe_alloc

// File: logic/stk_pipe_mem_sram.sv
module stk_pipe_mem_sram #(
  parameter int W = 32
, parameter int DEPTH = 8
) (
  input wire logic                      clk
, input wire logic                      i_ce
, input wire logic [$clog2(DEPTH)-1:0]  i_raddr
, input wire logic                      i_we
, input wire logic [$clog2(DEPTH)-1:0]  i_waddr
, input wire logic [W-1:0]              i_din
, output logic [W-1:0]                  o_dout
);

  // Storage array
  logic [W-1:0] mem [0:DEPTH-1];

  // Write port
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_din;
    end
  end

  // Read port, output held between enables
  always_ff @(posedge clk) begin
    if (i_ce) begin
      o_dout <= mem[i_raddr];
    end
  end

endmodule : stk_pipe_mem_sram

// File: logic/stk_pkg.sv
package stk_pkg;

  // Engines, one stack each
  localparam int ENG_N = 4;
  localparam int ENGID_W = $clog2(ENG_N);

  // Banked line storage
  localparam int BANKS_N = 2;
  localparam int BANK_W = $clog2(BANKS_N);
  localparam int LINES_N = 8;
  localparam int LINE_W = $clog2(LINES_N);

  // Flat pointer space across all banks
  localparam int PTR_W = BANK_W + LINE_W;
  localparam int PTRS_N = BANKS_N * LINES_N;

  typedef logic [ENGID_W-1:0] engid_t;

  typedef enum logic [1:0] {
    OPCODE_PUSH = 2'd0,
    OPCODE_POP  = 2'd1,
    OPCODE_PEEK = 2'd2
  } opcode_t;

  typedef enum logic [1:0] {
    STATUS_OK    = 2'd0,
    // POP or PEEK on an empty stack
    STATUS_EMPTY = 2'd1,
    // PUSH with no free line left
    STATUS_FULL  = 2'd2
  } status_t;

  // Flat index for the bitmap, bank/line for addressing
  typedef union packed {
    logic [PTR_W-1:0] raw;
    struct packed {
      logic [BANK_W-1:0] bank;
      logic [LINE_W-1:0] line;
    } fld;
  } ptr_u;

  // Link word, points at the line pushed before this one
  typedef struct packed {
    logic vld;
    ptr_u ptr;
  } link_t;

  typedef struct packed {
    opcode_t opcode;
    engid_t engid;
  } cmd_t;

  // LK to MEM microcode
  typedef struct packed {
    engid_t engid;
    opcode_t opcode;
    status_t status;
    logic [BANKS_N-1:0] bank;
    logic head_vld;
    logic head_upt;
    ptr_u head_ptr;
  } uc_t;

  // MEM to WRBK microcode, also the response
  typedef struct packed {
    engid_t engid;
    opcode_t opcode;
    status_t status;
    logic head_vld;
    ptr_u head_ptr;
    logic rel_vld;
    ptr_u rel_ptr;
  } wrbk_t;

endpackage : stk_pkg
